//--- list.f
design/fft_stream_pkg.sv
design/sample_fifo.sv
design/frame_ctrl.sv
design/frame_packer.sv
design/result_unpacker.sv
design/fft_stream_top.sv
verif/fft_stream_checker.sv
verif/tb_fft_stream.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		-f list.f --top-module tb_fft_stream
	./obj_dir/Vtb_fft_stream > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_fft_stream.sv
`timescale 1ns/100ps

module tb_fft_stream;

    localparam int DIN_W  = 16;
    localparam int DOUT_W = 32;
    localparam int FRAME  = 16;
    localparam int DEPTH  = 64;
    localparam int N_ROWS = 5;

    // name, samples, write gap (0 none, 1 one idle cycle, 2 random 0..3),
    // percent of cycles with tready low, overflow expected
    string row_name [N_ROWS] = '{"single_frame", "gapped_writes", "random_ready",
                                 "random_both", "overflow"};
    int    row_len  [N_ROWS] = '{16, 32, 48, 64, 80};
    int    row_gap  [N_ROWS] = '{0, 1, 0, 2, 0};
    int    row_low  [N_ROWS] = '{0, 0, 50, 30, 100};  // 100 holds tready low while writing
    logic  row_ovf  [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic                clk = 1'b0;
    logic                rst_n;
    logic                i_wd_en;
    logic [DIN_W-1:0]    i_wd_data;
    logic                o_overflow;
    logic                o_fft_tvalid;
    logic [2*DIN_W-1:0]  o_fft_tdata;
    logic                o_fft_tlast;
    logic                i_fft_tready = 1'b0;
    logic                o_cfg_tvalid;
    logic                i_res_tvalid = 1'b0;
    logic [2*DOUT_W-1:0] i_res_tdata = '0;
    logic                i_res_tlast = 1'b0;
    logic                o_rd_en;
    logic [DOUT_W-1:0]   o_data_re;
    logic [DOUT_W-1:0]   o_data_im;
    logic                o_sop;
    logic                o_eop;
    logic                row_done;
    logic                ovf_exp;
    logic                chk_busy;
    logic [DIN_W-1:0]    frame_q[$];    // beats taken by the core stand-in
    logic [DIN_W-1:0]    res_smp;
    logic [DOUT_W-1:0]   res_re;
    int                  err_cnt;
    int                  seed = 32'h3ab3;
    int                  ready_low_pct = 0;
    int                  cycle_cnt = 0;
    int                  cycle_limit = 2000;

    always #5 clk = ~clk;

    fft_stream_top #(
        .DATAIN_WIDTH  (DIN_W),
        .DATAOUT_WIDTH (DOUT_W),
        .FRAME_LEN     (FRAME),
        .FIFO_DEPTH    (DEPTH)
    ) u_dut (.*);

    fft_stream_checker #(
        .DATAIN_WIDTH  (DIN_W),
        .DATAOUT_WIDTH (DOUT_W),
        .FRAME_LEN     (FRAME),
        .FIFO_DEPTH    (DEPTH)
    ) u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wd_en      (i_wd_en),
        .i_wd_data    (i_wd_data),
        .i_overflow   (o_overflow),
        .i_cfg_tvalid (o_cfg_tvalid),
        .i_fft_tvalid (o_fft_tvalid),
        .i_fft_tdata  (o_fft_tdata),
        .i_fft_tlast  (o_fft_tlast),
        .i_fft_tready (i_fft_tready),
        .i_res_tvalid (i_res_tvalid),
        .i_res_tdata  (i_res_tdata),
        .i_rd_en      (o_rd_en),
        .i_data_re    (o_data_re),
        .i_data_im    (o_data_im),
        .i_sop        (o_sop),
        .i_eop        (o_eop),
        .i_row_done   (row_done),
        .i_ovf_exp    (ovf_exp),
        .o_err_cnt    (err_cnt),
        .o_busy       (chk_busy)
    );

    task automatic write_samples(input int n, input int gap_mode);
        int idle;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            i_wd_en   = 1'b1;
            i_wd_data = DIN_W'($random(seed));
            idle = (gap_mode == 2) ? int'($unsigned($random(seed)) % 4) : gap_mode;
            repeat (idle) begin
                @(negedge clk);
                i_wd_en = 1'b0;
            end
        end
        @(negedge clk);
        i_wd_en = 1'b0;
    endtask

    // core stand-in with random tready, echoing each frame as re = x and im = -x
    always @(negedge clk) begin
        i_fft_tready = (int'($unsigned($random(seed)) % 100) >= ready_low_pct);
    end

    always @(posedge clk) begin
        if (o_fft_tvalid && i_fft_tready) begin
            frame_q.push_back(o_fft_tdata[DIN_W-1:0]);
        end
    end

    always begin
        @(negedge clk);
        if (frame_q.size() >= FRAME) begin
            repeat (3) @(negedge clk);  // core latency
            for (int k = 0; k < FRAME; k++) begin
                res_smp      = frame_q.pop_front();
                res_re       = {{(DOUT_W-DIN_W){res_smp[DIN_W-1]}}, res_smp};
                i_res_tvalid = 1'b1;
                i_res_tdata  = {-res_re, res_re};
                i_res_tlast  = (k == FRAME - 1);
                @(negedge clk);
            end
            i_res_tvalid = 1'b0;
            i_res_tlast  = 1'b0;
            i_res_tdata  = '0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int err_before;
        rst_n     = 1'b0;
        i_wd_en   = 1'b0;
        i_wd_data = '0;
        row_done  = 1'b0;
        ovf_exp   = 1'b0;
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit += 4 * row_len[r];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (6) @(negedge clk);   // outputs must stay idle here

        for (int r = 0; r < N_ROWS; r++) begin
            err_before    = err_cnt;
            ready_low_pct = row_low[r];
            write_samples(row_len[r], row_gap[r]);
            if (row_low[r] >= 100) begin
                ready_low_pct = 0;   // let the core drain what was kept
            end
            do begin
                @(negedge clk);
            end while (chk_busy);
            ovf_exp  = row_ovf[r];
            row_done = 1'b1;
            @(negedge clk);
            row_done = 1'b0;
            @(negedge clk);
            $display("test %0d %s %0d samples, %0d errors",
                     r, row_name[r], row_len[r], err_cnt - err_before);
        end

        $display("summary: %0d tests, %0d errors", N_ROWS, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verif/fft_stream_checker.sv
`timescale 1ns/100ps

module fft_stream_checker #(
    parameter int DATAIN_WIDTH  = 16,
    parameter int DATAOUT_WIDTH = 32,
    parameter int FRAME_LEN     = 1024,
    parameter int FIFO_DEPTH    = 2048
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_wd_en,
    input  logic [DATAIN_WIDTH-1:0]    i_wd_data,
    input  logic                       i_overflow,
    input  logic                       i_cfg_tvalid,
    input  logic                       i_fft_tvalid,
    input  logic [2*DATAIN_WIDTH-1:0]  i_fft_tdata,
    input  logic                       i_fft_tlast,
    input  logic                       i_fft_tready,
    input  logic                       i_res_tvalid,
    input  logic [2*DATAOUT_WIDTH-1:0] i_res_tdata,
    input  logic                       i_rd_en,
    input  logic [DATAOUT_WIDTH-1:0]   i_data_re,
    input  logic [DATAOUT_WIDTH-1:0]   i_data_im,
    input  logic                       i_sop,
    input  logic                       i_eop,
    input  logic                       i_row_done,
    input  logic                       i_ovf_exp,
    output int                         o_err_cnt,
    output logic                       o_busy
);

    logic [DATAIN_WIDTH-1:0]    exp_q[$];   // written and not yet taken by the core
    logic [DATAIN_WIDTH-1:0]    res_q[$];   // taken with the result word still pending
    logic [DATAIN_WIDTH-1:0]    s;
    logic [DATAOUT_WIDTH-1:0]   re_exp;
    logic [2*DATAIN_WIDTH-1:0]  held_tdata;
    logic [2*DATAOUT_WIDTH-1:0] last_res;
    logic                       held_tlast;
    logic                       was_stall;
    logic                       last_res_vld;
    logic                       busy;
    int                         err_cnt = 0;
    int                         cyc;
    int                         wr_total;
    int                         drop_cnt;
    int                         beat_cnt;
    int                         word_cnt;

    assign o_err_cnt = err_cnt;
    assign o_busy    = busy;

    task automatic flag_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            res_q.delete();
            cyc          = 0;
            wr_total     = 0;
            drop_cnt     = 0;
            beat_cnt     = 0;
            word_cnt     = 0;
            was_stall    = 1'b0;
            last_res_vld = 1'b0;
            busy         = 1'b0;
        end else begin
            if (i_cfg_tvalid !== (cyc == 0))
                flag_error($sformatf("cfg tvalid %0b in cycle %0d after reset",
                                     i_cfg_tvalid, cyc));
            if (wr_total == 0 && (i_rd_en || i_sop || i_eop))
                flag_error("result output active before any sample");
            if (i_fft_tvalid && beat_cnt % FRAME_LEN == 0 && exp_q.size() < FRAME_LEN)
                flag_error("frame toward the core started before a whole frame was written");
            if (was_stall && (!i_fft_tvalid || i_fft_tdata !== held_tdata ||
                              i_fft_tlast !== held_tlast))
                flag_error("beat toward the core changed while stalled");

            // beat taken by the core
            if (i_fft_tvalid && i_fft_tready) begin
                if (exp_q.size() == 0) begin
                    flag_error("beat taken with no sample pending");
                end else begin
                    s = exp_q.pop_front();
                    if (i_fft_tdata !== {{DATAIN_WIDTH{1'b0}}, s})
                        flag_error($sformatf("tdata %h, expected %h", i_fft_tdata, s));
                    if (i_fft_tlast !== (beat_cnt % FRAME_LEN == FRAME_LEN - 1))
                        flag_error($sformatf("tlast %0b on beat %0d", i_fft_tlast, beat_cnt));
                    res_q.push_back(s);
                end
                beat_cnt++;
            end

            // result words trail the core beat by one cycle
            if (i_rd_en !== last_res_vld)
                flag_error("rd_en not one cycle after result tvalid");
            if (i_rd_en) begin
                if ({i_data_im, i_data_re} !== last_res)
                    flag_error("output word differs from the core beat");
                if (res_q.size() == 0) begin
                    flag_error("result word with no sample sent");
                end else begin
                    s      = res_q.pop_front();
                    re_exp = {{(DATAOUT_WIDTH-DATAIN_WIDTH){s[DATAIN_WIDTH-1]}}, s};
                    if (i_data_re !== re_exp || i_data_im !== -re_exp)
                        flag_error($sformatf("result re %h im %h for sample %h",
                                             i_data_re, i_data_im, s));
                end
                if (i_sop !== (word_cnt % FRAME_LEN == 0))
                    flag_error($sformatf("sop %0b on word %0d", i_sop, word_cnt));
                if (i_eop !== (word_cnt % FRAME_LEN == FRAME_LEN - 1))
                    flag_error($sformatf("eop %0b on word %0d", i_eop, word_cnt));
                word_cnt++;
            end else if (i_data_re !== '0 || i_data_im !== '0 || i_sop || i_eop) begin
                flag_error("result outputs not idle between words");
            end

            if (i_overflow && drop_cnt == 0)
                flag_error("overflow set with no sample dropped");
            if (i_row_done && (i_overflow !== i_ovf_exp || (drop_cnt != 0) !== i_ovf_exp))
                flag_error($sformatf("overflow %0b after %0d drops, expected %0b",
                                     i_overflow, drop_cnt, i_ovf_exp));

            // queue mirrors the fifo fill while the core holds off
            if (i_wd_en) begin
                wr_total++;
                if (exp_q.size() < FIFO_DEPTH)
                    exp_q.push_back(i_wd_data);
                else
                    drop_cnt++;
            end

            was_stall    = i_fft_tvalid && !i_fft_tready;
            held_tdata   = i_fft_tdata;
            held_tlast   = i_fft_tlast;
            last_res_vld = i_res_tvalid;
            last_res     = i_res_tdata;
            busy         = (exp_q.size() != 0) || (res_q.size() != 0);
            cyc++;
        end
    end

endmodule

//--- design/fft_stream_top.sv
`timescale 1ns/100ps

module fft_stream_top
    import fft_stream_pkg::*;
#(
    parameter int DATAIN_WIDTH  = 16,
    parameter int DATAOUT_WIDTH = 32,
    parameter int FRAME_LEN     = 1024,
    parameter int FIFO_DEPTH    = 2048   // power of two, at least FRAME_LEN
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // user samples in
    input  logic                       i_wd_en,
    input  logic [DATAIN_WIDTH-1:0]    i_wd_data,
    output logic                       o_overflow,
    // stream toward the core
    output logic                       o_fft_tvalid,
    output logic [2*DATAIN_WIDTH-1:0]  o_fft_tdata,
    output logic                       o_fft_tlast,
    input  logic                       i_fft_tready,
    output logic                       o_cfg_tvalid,
    // results from the core
    input  logic                       i_res_tvalid,
    input  logic [2*DATAOUT_WIDTH-1:0] i_res_tdata,
    input  logic                       i_res_tlast,
    // user results out
    output logic                       o_rd_en,
    output logic [DATAOUT_WIDTH-1:0]   o_data_re,
    output logic [DATAOUT_WIDTH-1:0]   o_data_im,
    output logic                       o_sop,
    output logic                       o_eop
);

    localparam int LW = CNT_W(FIFO_DEPTH);

    logic [LW-1:0]           fifo_level;
    logic [DATAIN_WIDTH-1:0] fifo_rd_data;
    logic                    pop;        // fifo read and packer load
    logic                    pop_last;
    logic                    stall;

    sample_fifo #(
        .DATAIN_WIDTH (DATAIN_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wd_en    (i_wd_en),
        .i_wd_data  (i_wd_data),
        .i_rd_en    (pop),
        .o_rd_data  (fifo_rd_data),
        .o_empty    (),              // level covers the frame decision
        .o_level    (fifo_level),
        .o_overflow (o_overflow)
    );

    frame_ctrl #(
        .FRAME_LEN  (FRAME_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_level      (fifo_level),
        .i_fft_tready (i_fft_tready),
        .i_stall      (stall),
        .o_pop        (pop),
        .o_pop_last   (pop_last),
        .o_cfg_tvalid (o_cfg_tvalid)
    );

    frame_packer #(
        .DATAIN_WIDTH (DATAIN_WIDTH)
    ) u_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_load       (pop),
        .i_load_last  (pop_last),
        .i_sample     (fifo_rd_data),
        .i_fft_tready (i_fft_tready),
        .o_fft_tvalid (o_fft_tvalid),
        .o_fft_tdata  (o_fft_tdata),
        .o_fft_tlast  (o_fft_tlast),
        .o_stall      (stall)
    );

    result_unpacker #(
        .DATAOUT_WIDTH (DATAOUT_WIDTH)
    ) u_unpack (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_res_tvalid (i_res_tvalid),
        .i_res_tdata  (i_res_tdata),
        .i_res_tlast  (i_res_tlast),
        .o_rd_en      (o_rd_en),
        .o_data_re    (o_data_re),
        .o_data_im    (o_data_im),
        .o_sop        (o_sop),
        .o_eop        (o_eop)
    );

endmodule

//--- design/result_unpacker.sv
`timescale 1ns/100ps

module result_unpacker #(
    parameter int DATAOUT_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_res_tvalid,
    input  logic [2*DATAOUT_WIDTH-1:0] i_res_tdata,
    input  logic                       i_res_tlast,
    output logic                       o_rd_en,
    output logic [DATAOUT_WIDTH-1:0]   o_data_re,
    output logic [DATAOUT_WIDTH-1:0]   o_data_im,
    output logic                       o_sop,
    output logic                       o_eop
);

    logic r_vld_d1;     // o_rd_en delayed once more
    logic r_last_d0;
    logic r_last_d1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_en   <= 1'b0;
            r_vld_d1  <= 1'b0;
            r_last_d0 <= 1'b0;
            r_last_d1 <= 1'b0;
        end else begin
            o_rd_en   <= i_res_tvalid;
            r_vld_d1  <= o_rd_en;
            r_last_d0 <= i_res_tvalid && i_res_tlast;  // tlast only counts with valid
            r_last_d1 <= r_last_d0;
        end
    end

    // re in the low half, im in the high half; zero between beats
    always_ff @(posedge clk) begin
        if (i_res_tvalid) begin
            o_data_re <= i_res_tdata[DATAOUT_WIDTH-1:0];
            o_data_im <= i_res_tdata[2*DATAOUT_WIDTH-1:DATAOUT_WIDTH];
        end else begin
            o_data_re <= '0;
            o_data_im <= '0;
        end
    end

    assign o_sop = o_rd_en && !r_vld_d1;     // first word of a burst
    assign o_eop = r_last_d0 && !r_last_d1;

endmodule

//--- design/frame_packer.sv
`timescale 1ns/100ps

module frame_packer #(
    parameter int DATAIN_WIDTH = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_load,
    input  logic                      i_load_last,
    input  logic [DATAIN_WIDTH-1:0]   i_sample,
    input  logic                      i_fft_tready,
    output logic                      o_fft_tvalid,
    output logic [2*DATAIN_WIDTH-1:0] o_fft_tdata,
    output logic                      o_fft_tlast,
    output logic                      o_stall
);

    logic accepted;

    assign accepted = o_fft_tvalid && i_fft_tready;
    assign o_stall  = o_fft_tvalid && !i_fft_tready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_fft_tvalid <= 1'b0;
            o_fft_tlast  <= 1'b0;
        end else if (i_load) begin
            o_fft_tvalid <= 1'b1;
            o_fft_tlast  <= i_load_last;
        end else if (accepted) begin
            o_fft_tvalid <= 1'b0;  // beat gone, nothing new behind it
            o_fft_tlast  <= 1'b0;
        end
    end

    // real sample in the low half, imaginary half zero
    always_ff @(posedge clk) begin
        if (i_load) begin
            o_fft_tdata <= {{DATAIN_WIDTH{1'b0}}, i_sample};
        end
    end

    // a stalled beat must reach the core unchanged on the next cycle
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        o_stall |=> (o_fft_tvalid && $stable(o_fft_tdata) && $stable(o_fft_tlast)))
        else $error("beat toward the core changed while stalled");

endmodule

//--- design/frame_ctrl.sv
`timescale 1ns/100ps

module frame_ctrl
    import fft_stream_pkg::*;
#(
    parameter int FRAME_LEN  = 1024,
    parameter int FIFO_DEPTH = 2048
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [CNT_W(FIFO_DEPTH)-1:0] i_level,
    input  logic                         i_fft_tready,
    input  logic                         i_stall,
    output logic                         o_pop,
    output logic                         o_pop_last,
    output logic                         o_cfg_tvalid
);

    localparam int LW = CNT_W(FIFO_DEPTH);
    localparam int BW = CNT_W(FRAME_LEN);
    localparam logic [BW-1:0] LAST_BEAT = BW'(FRAME_LEN - 1);

    ctrl_state_t   state;
    ctrl_state_t   state_nxt;
    logic [BW-1:0] beat_cnt;     // pops made in the current frame
    logic          at_last;
    logic          frame_ready;

    // a whole frame buffered, so a started frame never drains the fifo
    assign frame_ready = (i_level >= LW'(FRAME_LEN)) && i_fft_tready;
    assign at_last     = (beat_cnt == LAST_BEAT);

    assign o_cfg_tvalid = (state == ST_CFG);  // exactly one cycle out of reset

    always_comb begin
        state_nxt  = state;
        o_pop      = 1'b0;
        o_pop_last = 1'b0;
        case (state)
            ST_CFG: begin
                state_nxt = ST_IDLE;
            end
            ST_IDLE: begin
                o_pop = frame_ready;
            end
            ST_SEND: begin
                o_pop = !i_stall;  // one pop per beat the packer can take
            end
            ST_LAST_WAIT: begin
                // packer holds tvalid here, so no stall means accepted
                if (!i_stall) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase

        if (o_pop) begin
            o_pop_last = at_last;
            state_nxt  = at_last ? ST_LAST_WAIT : ST_SEND;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_CFG;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (o_pop_last) begin
            beat_cnt <= '0;
        end else if (o_pop) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // fifo level comes from the other side, check the frame gate holds
    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        o_pop |-> (i_level != '0))
        else $error("pop issued with an empty fifo");

endmodule

//--- design/sample_fifo.sv
`timescale 1ns/100ps

module sample_fifo
    import fft_stream_pkg::*;
#(
    parameter int DATAIN_WIDTH = 16,
    parameter int FIFO_DEPTH   = 2048
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_wd_en,
    input  logic [DATAIN_WIDTH-1:0]      i_wd_data,
    input  logic                         i_rd_en,
    output logic [DATAIN_WIDTH-1:0]      o_rd_data,
    output logic                         o_empty,
    output logic [CNT_W(FIFO_DEPTH)-1:0] o_level,
    output logic                         o_overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int LW = CNT_W(FIFO_DEPTH);

    logic [DATAIN_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [LW-1:0]           count;
    logic                    r_wd_en;
    logic [DATAIN_WIDTH-1:0] r_wd_data;
    logic                    full;
    logic                    wr_go;
    logic                    rd_go;

    assign full  = (count == LW'(FIFO_DEPTH));
    assign wr_go = r_wd_en && !full;    // a sample on a full fifo is dropped
    assign rd_go = i_rd_en && !o_empty;

    assign o_empty   = (count == '0);
    assign o_level   = count;
    assign o_rd_data = mem[rd_ptr];     // show-ahead, head word always visible

    // input strobe is registered once before the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_wd_en    <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            r_wd_en <= i_wd_en;
            if (wr_go) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
            end
            if (rd_go) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_go, rd_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (r_wd_en && full) begin
                o_overflow <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        r_wd_data <= i_wd_data;
        if (wr_go) begin
            mem[wr_ptr] <= r_wd_data;
        end
    end

    // the controller must only pop words that are already buffered
    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        i_rd_en |-> !o_empty)
        else $error("sample fifo read while empty");

    a_level_bound: assert property (@(posedge clk) disable iff (!rst_n)
        o_level <= LW'(FIFO_DEPTH))
        else $error("sample fifo level above depth");

endmodule

//--- design/fft_stream_pkg.sv
package fft_stream_pkg;

    // control FSM states for the path toward the core
    typedef enum logic [1:0] {
        ST_CFG       = 2'd0,  // the one cycle after reset, config pulse
        ST_IDLE      = 2'd1,  // wait for a full frame and a ready core
        ST_SEND      = 2'd2,
        ST_LAST_WAIT = 2'd3   // last beat loaded, not yet taken
    } ctrl_state_t;

    // width of a counter that has to reach depth itself, not just depth-1
    function automatic int CNT_W(input int depth);
        return $clog2(depth) + 1;
    endfunction

endpackage
